// File: common/stepper_settings.svh
// stepper axis settings
`ifndef STEPPER_SETTINGS_SVH
`define STEPPER_SETTINGS_SVH

// host register bus
`define STEP_ADDR_W 4
`define STEP_DATA_W 32

// step generator
// period counter width in clocks
`define STEP_PERIOD_W 16
// clocks the step pin stays high
`define STEP_PULSE_LEN 4

// spi link to the driver chip
// system clocks per sck half period
`define SPI_CLK_DIV 4
// 8 bit address plus 32 bit data
`define SPI_FRAME_W 40

`endif

// File: common/stepper_pkg.sv
// stepper axis types
`include "stepper_settings.svh"

package stepper_pkg;

  // host bus request, strobes are single cycle
  typedef struct packed {
    logic [`STEP_ADDR_W-1:0] addr;
    logic [`STEP_DATA_W-1:0] wdata;
    logic                    write;
    logic                    read;
  } bus_req_t;

  // axis configuration from the ctrl and period registers
  typedef struct packed {
    logic                      enable;
    logic                      direction;
    logic [`STEP_PERIOD_W-1:0] period;
  } motor_cfg_t;

  // one spi datagram, same layout both ways
  // rx side carries the chip status byte in addr
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } spi_frame_t;

  // status register bits, drv_en in bit 0
  typedef struct packed {
    logic spi_busy;
    logic moving;
    logic drv_en;
  } motor_status_t;

  // register map
  localparam logic [`STEP_ADDR_W-1:0] REG_CTRL     = 4'd0;
  localparam logic [`STEP_ADDR_W-1:0] REG_PERIOD   = 4'd1;
  localparam logic [`STEP_ADDR_W-1:0] REG_STEPS    = 4'd2;
  localparam logic [`STEP_ADDR_W-1:0] REG_SPI_DATA = 4'd3;
  localparam logic [`STEP_ADDR_W-1:0] REG_SPI_ADDR = 4'd4;
  localparam logic [`STEP_ADDR_W-1:0] REG_STATUS   = 4'd5;
  localparam logic [`STEP_ADDR_W-1:0] REG_POSITION = 4'd6;
  localparam logic [`STEP_ADDR_W-1:0] REG_RX_DATA  = 4'd7;
  localparam logic [`STEP_ADDR_W-1:0] REG_RX_ADDR  = 4'd8;

endpackage

// File: logic/io_register.sv
// host register file
`timescale 1ns/1ps
`include "stepper_settings.svh"

module io_register
  import stepper_pkg::*;
(
  input  logic                    clk_in,
  input  logic                    arst_n,
  input  bus_req_t                host_req,
  input  motor_status_t           status,
  input  spi_frame_t              rx_frame,
  input  logic signed [31:0]      position,
  output logic [`STEP_DATA_W-1:0] host_rdata,
  output motor_cfg_t              cfg,
  output spi_frame_t              tx_frame,
  output logic                    move_go,
  output logic [31:0]             move_steps,
  output logic                    spi_go
);

  logic [`STEP_DATA_W-1:0] rd_mux;

  // config register and command pulses
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      cfg     <= '0;
      move_go <= 1'b0;
      spi_go  <= 1'b0;
    end else begin
      // pulses last one cycle
      move_go <= 1'b0;
      spi_go  <= 1'b0;
      if (host_req.write) begin
        case (host_req.addr)
          REG_CTRL: begin
            cfg.enable    <= host_req.wdata[0];
            cfg.direction <= host_req.wdata[1];
          end
          REG_PERIOD:   cfg.period <= host_req.wdata[`STEP_PERIOD_W-1:0];
          // writing the step count starts a move
          REG_STEPS:    move_go <= 1'b1;
          // address byte is written last, kicks the transfer
          REG_SPI_ADDR: spi_go <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // outgoing frame and step count
  always_ff @(posedge clk_in) begin
    if (host_req.write) begin
      case (host_req.addr)
        REG_STEPS:    move_steps    <= host_req.wdata;
        REG_SPI_DATA: tx_frame.data <= host_req.wdata;
        REG_SPI_ADDR: tx_frame.addr <= host_req.wdata[7:0];
        default: ;
      endcase
    end
  end

  // read mux, unmapped reads as zero
  always_comb begin
    rd_mux = '0;
    case (host_req.addr)
      REG_CTRL:     rd_mux[1:0] = {cfg.direction, cfg.enable};
      REG_PERIOD:   rd_mux[`STEP_PERIOD_W-1:0] = cfg.period;
      REG_STEPS:    rd_mux = move_steps;
      REG_SPI_DATA: rd_mux = tx_frame.data;
      REG_SPI_ADDR: rd_mux[7:0] = tx_frame.addr;
      REG_STATUS:   rd_mux[2:0] = status;
      REG_POSITION: rd_mux = position;
      REG_RX_DATA:  rd_mux = rx_frame.data;
      REG_RX_ADDR:  rd_mux[7:0] = rx_frame.addr;
      default:      rd_mux = '0;
    endcase
  end

  // read data valid the cycle after the strobe
  always_ff @(posedge clk_in) begin
    if (host_req.read) begin
      host_rdata <= rd_mux;
    end
  end

endmodule

// File: motor/motor_driver.sv
// axis control fsm
`timescale 1ns/1ps

module motor_driver
  import stepper_pkg::*;
(
  input  logic          clk_in,
  input  logic          arst_n,
  input  motor_cfg_t    cfg,
  input  logic          move_go,
  input  logic          spi_go,
  input  logic          spi_done,
  input  logic          moving,
  input  logic          pulse_high,
  output logic          spi_start,
  output logic          step_run,
  output logic          load,
  output motor_status_t status,
  output logic          drv_en_n
);

  typedef enum logic [1:0] {ST_OFF, ST_CONFIG, ST_ENABLED, ST_STOPPING} state_t;

  state_t state;
  logic   spi_busy;
  logic   pending;
  logic   cfg_started;
  logic   spi_req;

  // host transfer or the config datagram on enable
  assign spi_req   = spi_go | ((state == ST_OFF) & cfg.enable);
  // one pending slot, started once the link is free
  assign spi_start = (spi_req | pending) & ~spi_busy;

  // stepping stops in the same cycle enable drops
  assign step_run = (state == ST_ENABLED) & cfg.enable;
  assign load     = move_go & step_run;

  assign status.spi_busy = spi_busy;
  assign status.moving   = moving;
  assign status.drv_en   = ~drv_en_n;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ST_OFF;
      spi_busy    <= 1'b0;
      pending     <= 1'b0;
      cfg_started <= 1'b0;
      drv_en_n    <= 1'b1;
    end else begin
      if (spi_start) begin
        spi_busy <= 1'b1;
      end else if (spi_done) begin
        spi_busy <= 1'b0;
      end
      // newer request just overwrites the slot
      if (spi_start) begin
        pending <= 1'b0;
      end else if (spi_req) begin
        pending <= 1'b1;
      end
      case (state)
        ST_OFF: begin
          if (cfg.enable) begin
            state       <= ST_CONFIG;
            cfg_started <= spi_start;
          end
        end
        ST_CONFIG: begin
          // a done from an older host transfer is not ours
          if (!cfg.enable) begin
            state       <= ST_OFF;
            cfg_started <= 1'b0;
          end else if (spi_done && cfg_started) begin
            state       <= ST_ENABLED;
            cfg_started <= 1'b0;
            drv_en_n    <= 1'b0;
          end else if (spi_start) begin
            cfg_started <= 1'b1;
          end
        end
        ST_ENABLED: begin
          if (!cfg.enable) begin
            state <= ST_STOPPING;
          end
        end
        // let a running pulse finish before dropping the driver
        ST_STOPPING: begin
          if (!pulse_high) begin
            state    <= ST_OFF;
            drv_en_n <= 1'b1;
          end
        end
        default: state <= ST_OFF;
      endcase
    end
  end

endmodule

// File: motor/spi_shift.sv
// spi datagram master
`timescale 1ns/1ps
`include "stepper_settings.svh"

module spi_shift
  import stepper_pkg::*;
(
  input  logic       clk_in,
  input  logic       arst_n,
  input  logic       start,
  input  spi_frame_t tx_frame,
  input  logic       sdo,
  output logic       sck,
  output logic       sdi,
  output logic       cs_n,
  output spi_frame_t rx_frame,
  output logic       done
);

  // 80 sck edges then two idle half periods before cs_n rises
  localparam int unsigned SCK_EDGES = 2 * `SPI_FRAME_W;
  localparam int unsigned LAST_EDGE = SCK_EDGES + 1;
  localparam int unsigned EDGE_W    = $clog2(LAST_EDGE + 1);
  localparam int unsigned DIV_W     = $clog2(`SPI_CLK_DIV + 1);

  logic                    active;
  logic                    tick;
  logic [DIV_W-1:0]        div_cnt;
  logic [EDGE_W-1:0]       edge_cnt;
  logic [`SPI_FRAME_W-1:0] tx_shift;
  logic [`SPI_FRAME_W-1:0] rx_shift;
  logic [1:0]              sdo_sync;

  // one tick per sck half period
  assign tick = active && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  // msb first
  assign sdi  = tx_shift[`SPI_FRAME_W-1];

  // sdo crosses in from the chip
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      sdo_sync <= '0;
    end else begin
      sdo_sync <= {sdo_sync[0], sdo};
    end
  end

  // mode 3, sck idles high
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      active   <= 1'b0;
      div_cnt  <= '0;
      edge_cnt <= '0;
      sck      <= 1'b1;
      cs_n     <= 1'b1;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !active) begin
        active   <= 1'b1;
        cs_n     <= 1'b0;
        div_cnt  <= '0;
        edge_cnt <= '0;
      end else if (active) begin
        div_cnt <= tick ? '0 : div_cnt + 1'b1;
        if (tick) begin
          edge_cnt <= edge_cnt + 1'b1;
          if (edge_cnt < SCK_EDGES) begin
            sck <= ~sck;
          end
          // done goes out together with cs_n
          if (edge_cnt == LAST_EDGE) begin
            active <= 1'b0;
            cs_n   <= 1'b1;
            done   <= 1'b1;
          end
        end
      end
    end
  end

  // even edges fall, odd edges rise
  always_ff @(posedge clk_in) begin
    if (start && !active) begin
      tx_shift <= tx_frame;
    end else if (tick && !edge_cnt[0] && edge_cnt != 0 && edge_cnt < SCK_EDGES) begin
      // next bit on each falling edge after the first
      tx_shift <= {tx_shift[`SPI_FRAME_W-2:0], 1'b0};
    end
    if (tick && edge_cnt[0] && edge_cnt < SCK_EDGES) begin
      rx_shift <= {rx_shift[`SPI_FRAME_W-2:0], sdo_sync[1]};
    end
    if (tick && edge_cnt == LAST_EDGE) begin
      rx_frame <= rx_shift;
    end
  end

endmodule

// File: motor/step_gen.sv
// step pulse generator
`timescale 1ns/1ps
`include "stepper_settings.svh"

module step_gen (
  input  logic                      clk_in,
  input  logic                      arst_n,
  input  logic                      run,
  input  logic                      load,
  input  logic [31:0]               steps,
  input  logic [`STEP_PERIOD_W-1:0] period,
  input  logic                      direction,
  output logic                      step,
  output logic                      dir,
  output logic                      moving,
  output logic                      pulse_high,
  output logic signed [31:0]        position
);

  // period never shorter than high plus low time
  localparam logic [`STEP_PERIOD_W-1:0] MIN_PERIOD = 2 * `STEP_PULSE_LEN;
  localparam int unsigned PULSE_W = $clog2(`STEP_PULSE_LEN + 1);

  logic [`STEP_PERIOD_W-1:0] period_clamped;
  logic [`STEP_PERIOD_W-1:0] timer;
  logic [31:0]               remaining;
  logic [PULSE_W-1:0]        pulse_cnt;
  logic                      dir_next;
  logic                      fire_load;
  logic                      fire_next;

  assign period_clamped = (period < MIN_PERIOD) ? MIN_PERIOD : period;
  // direction only latched while idle
  assign dir_next   = moving ? dir : direction;
  // first step straight off the load
  assign fire_load  = load & run & (steps != 0);
  assign fire_next  = run & ~load & (remaining != 0) & (timer == 0);
  assign moving     = (remaining != 0) | step;
  assign pulse_high = step;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      step      <= 1'b0;
      dir       <= 1'b0;
      timer     <= '0;
      pulse_cnt <= '0;
      remaining <= '0;
      position  <= '0;
    end else begin
      if (!moving) begin
        dir <= direction;
      end
      if (fire_load || fire_next) begin
        step      <= 1'b1;
        pulse_cnt <= PULSE_W'(`STEP_PULSE_LEN - 1);
        timer     <= period_clamped - 1'b1;
        // count up when dir is low
        position  <= dir_next ? position - 32'sd1 : position + 32'sd1;
      end else begin
        if (step && pulse_cnt == 0) begin
          step <= 1'b0;
        end else if (step) begin
          pulse_cnt <= pulse_cnt - 1'b1;
        end
        if (timer != 0) begin
          timer <= timer - 1'b1;
        end
      end
      // dropping run throws away what is left
      if (!run) begin
        remaining <= '0;
      end else if (load) begin
        remaining <= (steps != 0) ? steps - 1'b1 : '0;
      end else if (fire_next) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

endmodule

// File: stepper_top.sv
// stepper axis top
`timescale 1ns/1ps
`include "stepper_settings.svh"

// board wrapper pinout
// gp[0] = step
// gp[1] = dir
// gp[2] = drv_en_n
// gn[0] = sdo
// gn[1] = cs_n
// gn[2] = sck
// gn[3] = sdi
module stepper_top
  import stepper_pkg::*;
(
  input  logic                    clk_25mhz,
  input  logic                    arst_n,
  input  bus_req_t                host_req,
  output logic [`STEP_DATA_W-1:0] host_rdata,
  input  logic                    sdo,
  output logic                    sck,
  output logic                    sdi,
  output logic                    cs_n,
  output logic                    step,
  output logic                    dir,
  output logic                    drv_en_n
);

  motor_cfg_t         cfg;
  spi_frame_t         tx_frame;
  spi_frame_t         rx_frame;
  motor_status_t      status;
  logic               move_go;
  logic [31:0]        move_steps;
  logic               spi_go;
  logic               spi_start;
  logic               spi_done;
  logic               step_run;
  logic               load;
  logic               moving;
  logic               pulse_high;
  logic signed [31:0] position;

  // host side registers
  io_register io (
    .clk_in    (clk_25mhz),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .status    (status),
    .rx_frame  (rx_frame),
    .position  (position),
    .host_rdata(host_rdata),
    .cfg       (cfg),
    .tx_frame  (tx_frame),
    .move_go   (move_go),
    .move_steps(move_steps),
    .spi_go    (spi_go)
  );

  // enable sequence and spi arbitration
  motor_driver driver (
    .clk_in    (clk_25mhz),
    .arst_n    (arst_n),
    .cfg       (cfg),
    .move_go   (move_go),
    .spi_go    (spi_go),
    .spi_done  (spi_done),
    .moving    (moving),
    .pulse_high(pulse_high),
    .spi_start (spi_start),
    .step_run  (step_run),
    .load      (load),
    .status    (status),
    .drv_en_n  (drv_en_n)
  );

  spi_shift spi (
    .clk_in  (clk_25mhz),
    .arst_n  (arst_n),
    .start   (spi_start),
    .tx_frame(tx_frame),
    .sdo     (sdo),
    .sck     (sck),
    .sdi     (sdi),
    .cs_n    (cs_n),
    .rx_frame(rx_frame),
    .done    (spi_done)
  );

  // step and dir pins come straight from here
  step_gen stepper (
    .clk_in    (clk_25mhz),
    .arst_n    (arst_n),
    .run       (step_run),
    .load      (load),
    .steps     (move_steps),
    .period    (cfg.period),
    .direction (cfg.direction),
    .step      (step),
    .dir       (dir),
    .moving    (moving),
    .pulse_high(pulse_high),
    .position  (position)
  );

endmodule

// File: bench/driver_chip_model.sv
// driver chip spi model
`timescale 1ns/1ps
`include "stepper_settings.svh"

module driver_chip_model
  import stepper_pkg::*;
(
  input  logic        sck,
  input  logic        sdi,
  input  logic        cs_n,
  output logic        sdo,
  output spi_frame_t  frame,
  output int unsigned frame_cnt
);

  localparam logic [7:0] CHIP_STATUS = 8'h5a;

  spi_frame_t              reply;
  logic [`SPI_FRAME_W-1:0] shift_in;
  int unsigned             bit_idx;
  logic                    in_frame;

  initial begin
    sdo       = 1'b1;
    frame     = '0;
    frame_cnt = 0;
    reply     = '0;
    shift_in  = '0;
    bit_idx   = 0;
    in_frame  = 1'b0;
  end

  // status byte then the data of the previous datagram
  always @(negedge cs_n) begin
    in_frame   = 1'b1;
    reply.addr = CHIP_STATUS;
    reply.data = frame.data;
    bit_idx    = 0;
    sdo <= reply[`SPI_FRAME_W-1];
  end

  // mode 3, chip shifts out on falling sck
  always @(negedge sck) begin
    if (in_frame && bit_idx < `SPI_FRAME_W) begin
      sdo <= reply[`SPI_FRAME_W-1-bit_idx];
      bit_idx = bit_idx + 1;
    end
  end

  // sdi taken on rising sck
  always @(posedge sck) begin
    if (in_frame) begin
      shift_in = {shift_in[`SPI_FRAME_W-2:0], sdi};
    end
  end

  // datagram complete on cs_n release
  always @(posedge cs_n) begin
    if (in_frame) begin
      in_frame = 1'b0;
      frame     <= shift_in;
      frame_cnt <= frame_cnt + 1;
    end
  end

endmodule

// File: bench/stepper_tb.sv
// stepper axis testbench
`timescale 1ns/1ps
`include "stepper_settings.svh"

module stepper_tb
  import stepper_pkg::*;
();

  // the whole run needs well under 10k clocks
  localparam int unsigned WATCHDOG_NS = 200_000;
  localparam int unsigned POLL_LIMIT  = 4000;
  localparam int unsigned MIN_PERIOD  = 2 * `STEP_PULSE_LEN;

  logic                    clk_25mhz;
  logic                    arst_n;
  bus_req_t                host_req;
  logic [`STEP_DATA_W-1:0] host_rdata;
  logic                    sdo;
  logic                    sck;
  logic                    sdi;
  logic                    cs_n;
  logic                    step;
  logic                    dir;
  logic                    drv_en_n;
  spi_frame_t              chip_frame;
  int unsigned             chip_frames;
  int unsigned             cycle_cnt;
  int unsigned             edge_cycle[$];
  logic                    step_q;

  stepper_top stepper_top_inst (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .host_rdata(host_rdata),
    .sdo       (sdo),
    .sck       (sck),
    .sdi       (sdi),
    .cs_n      (cs_n),
    .step      (step),
    .dir       (dir),
    .drv_en_n  (drv_en_n)
  );

  driver_chip_model chip (
    .sck      (sck),
    .sdi      (sdi),
    .cs_n     (cs_n),
    .sdo      (sdo),
    .frame    (chip_frame),
    .frame_cnt(chip_frames)
  );

  // 4 ns period
  always #2 clk_25mhz = ~clk_25mhz;

  // log step rising edges by cycle number
  // sampled on the falling clock
  always @(negedge clk_25mhz) begin
    cycle_cnt = cycle_cnt + 1;
    if (step && !step_q) begin
      edge_cycle.push_back(cycle_cnt);
    end
    step_q = step;
  end

  task automatic report_mismatch(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Run aborted because %s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic bus_write(input logic [`STEP_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk_25mhz);
    #1;
    host_req.addr  = addr;
    host_req.wdata = data;
    host_req.write = 1'b1;
    @(posedge clk_25mhz);
    #1;
    host_req.write = 1'b0;
  endtask

  // rdata registered on the edge after the strobe
  task automatic bus_read(input logic [`STEP_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk_25mhz);
    #1;
    host_req.addr = addr;
    host_req.read = 1'b1;
    @(posedge clk_25mhz);
    #1;
    host_req.read = 1'b0;
    data = host_rdata;
  endtask

  task automatic poll_status_clear(input int bit_idx, input string what);
    logic [31:0] rd;
    bit          cleared;
    cleared = 1'b0;
    for (int i = 0; i < POLL_LIMIT && !cleared; i++) begin
      bus_read(REG_STATUS, rd);
      cleared = !rd[bit_idx];
    end
    if (!cleared) begin
      abort_run($sformatf("%s never cleared in the status register", what));
    end
  endtask

  // idle dir pin follows the ctrl direction bit one clock after the write
  task automatic check_dir_pin(input bit expected);
    @(negedge clk_25mhz);
    @(negedge clk_25mhz);
    assert (dir === expected)
      else report_mismatch($sformatf("dir pin %b, expected %b", dir, expected));
  endtask

  // data word first then the address write kicks the transfer
  task automatic spi_transfer(input spi_frame_t frame);
    bus_write(REG_SPI_DATA, frame.data);
    bus_write(REG_SPI_ADDR, {24'h0, frame.addr});
    poll_status_clear(2, "spi_busy");
  endtask

  task automatic reset_levels();
    logic [31:0] rd;
    assert (step === 1'b0 && drv_en_n === 1'b1 && cs_n === 1'b1 && sck === 1'b1)
      else report_mismatch("pins not at their reset levels");
    bus_read(REG_STATUS, rd);
    assert (rd == 32'h0) else report_mismatch($sformatf("status %h after reset", rd));
    bus_read(REG_POSITION, rd);
    assert (rd == 32'h0) else report_mismatch($sformatf("position %h after reset", rd));
  endtask

  task automatic register_readback();
    logic [31:0]             period_val;
    logic [31:0]             data_val;
    logic [31:0]             ctrl_val;
    logic [31:0]             rd;
    logic [`STEP_ADDR_W-1:0] unmapped;
    period_val = {16'h0, 16'($urandom)};
    data_val   = $urandom;
    // enable stays low here
    ctrl_val   = {30'h0, 1'($urandom), 1'b0};
    unmapped   = 4'($urandom_range(9, 15));
    bus_write(REG_PERIOD, period_val);
    bus_write(REG_SPI_DATA, data_val);
    bus_write(REG_CTRL, ctrl_val);
    bus_read(REG_PERIOD, rd);
    assert (rd == period_val) else report_mismatch($sformatf("period read %h", rd));
    bus_read(REG_SPI_DATA, rd);
    assert (rd == data_val) else report_mismatch($sformatf("spi data read %h", rd));
    bus_read(REG_CTRL, rd);
    assert (rd == ctrl_val) else report_mismatch($sformatf("ctrl read %h", rd));
    bus_read(unmapped, rd);
    assert (rd == 32'h0) else report_mismatch($sformatf("unmapped %0d read %h", unmapped, rd));
  endtask

  task automatic spi_round_trip();
    spi_frame_t  first;
    spi_frame_t  second;
    logic [31:0] rd;
    int unsigned frames_before;
    first  = {8'($urandom), 32'($urandom)};
    second = {8'($urandom), 32'($urandom)};
    frames_before = chip_frames;
    spi_transfer(first);
    assert (chip_frames == frames_before + 1 && chip_frame == first)
      else report_mismatch($sformatf("chip got %h, sent %h", chip_frame, first));
    bus_read(REG_RX_ADDR, rd);
    assert (rd == 32'h5a) else report_mismatch($sformatf("rx status byte %h", rd));
    spi_transfer(second);
    assert (chip_frames == frames_before + 2 && chip_frame == second)
      else report_mismatch($sformatf("chip got %h, sent %h", chip_frame, second));
    bus_read(REG_RX_ADDR, rd);
    assert (rd == 32'h5a) else report_mismatch($sformatf("rx status byte %h", rd));
    // chip echoes the previous data word
    bus_read(REG_RX_DATA, rd);
    assert (rd == first.data) else report_mismatch($sformatf("rx data %h", rd));
  endtask

  task automatic enable_sequencing();
    spi_frame_t  expected;
    logic [31:0] rd;
    int unsigned frames_before;
    bit          cs_low_seen;
    bit          cs_returned;
    bit          enabled;
    cs_low_seen = 1'b0;
    cs_returned = 1'b0;
    enabled     = 1'b0;
    bus_read(REG_SPI_ADDR, rd);
    expected.addr = rd[7:0];
    expected.data = $urandom;
    // writing the data word alone starts no transfer
    bus_write(REG_SPI_DATA, expected.data);
    frames_before = chip_frames;
    bus_write(REG_CTRL, 32'h1);
    for (int i = 0; i < POLL_LIMIT && !enabled; i++) begin
      @(negedge clk_25mhz);
      enabled = !drv_en_n;
      // cs_n must be back high while the driver is still off
      if (!enabled && !cs_n) begin
        cs_low_seen = 1'b1;
      end
      if (!enabled && cs_low_seen && cs_n) begin
        cs_returned = 1'b1;
      end
    end
    if (!enabled) begin
      abort_run("drv_en_n never went low after enable was set");
    end
    assert (cs_returned) else report_mismatch("drv_en_n fell before cs_n returned high");
    assert (chip_frames == frames_before + 1 && chip_frame == expected)
      else report_mismatch($sformatf("config frame %h, expected %h", chip_frame, expected));
    bus_read(REG_STATUS, rd);
    assert (rd[0]) else report_mismatch($sformatf("status %h without drv_en", rd));
  endtask

  task automatic counted_move();
    logic [31:0] rd;
    int unsigned steps;
    int unsigned period;
    int unsigned spacing;
    bit          direction;
    int          pos_before;
    int          expected_pos;
    steps     = $urandom_range(5, 20);
    period    = $urandom_range(3, 30);
    direction = 1'($urandom);
    spacing   = (period < MIN_PERIOD) ? MIN_PERIOD : period;
    bus_write(REG_PERIOD, period);
    // both dir levels while idle
    bus_write(REG_CTRL, {30'h0, !direction, 1'b1});
    check_dir_pin(!direction);
    bus_write(REG_CTRL, {30'h0, direction, 1'b1});
    check_dir_pin(direction);
    bus_read(REG_POSITION, rd);
    pos_before = signed'(rd);
    edge_cycle.delete();
    bus_write(REG_STEPS, steps);
    poll_status_clear(1, "moving");
    assert (edge_cycle.size() == steps)
      else report_mismatch($sformatf("%0d step edges for %0d steps", edge_cycle.size(), steps));
    for (int i = 1; i < edge_cycle.size(); i++) begin
      assert (edge_cycle[i] - edge_cycle[i-1] == spacing)
        else report_mismatch($sformatf("step spacing %0d, expected %0d",
                                       edge_cycle[i] - edge_cycle[i-1], spacing));
    end
    // +1 per step when dir is 0
    expected_pos = direction ? pos_before - int'(steps) : pos_before + int'(steps);
    bus_read(REG_POSITION, rd);
    assert (signed'(rd) == expected_pos)
      else report_mismatch($sformatf("position %0d, expected %0d", signed'(rd), expected_pos));
  endtask

  task automatic disable_mid_move();
    logic [31:0] rd;
    bit          direction;
    bit          started;
    bit          dropped;
    int          pos_before;
    int          edges;
    int          expected_pos;
    started   = 1'b0;
    dropped   = 1'b0;
    direction = 1'($urandom);
    bus_write(REG_PERIOD, 20);
    bus_write(REG_CTRL, {30'h0, direction, 1'b1});
    bus_read(REG_POSITION, rd);
    pos_before = signed'(rd);
    edge_cycle.delete();
    bus_write(REG_STEPS, 200);
    // let a few steps out first
    for (int i = 0; i < POLL_LIMIT && !started; i++) begin
      @(posedge clk_25mhz);
      started = (edge_cycle.size() >= 5);
    end
    if (!started) begin
      abort_run("the long move never produced steps");
    end
    bus_write(REG_CTRL, {30'h0, direction, 1'b0});
    for (int i = 0; i < POLL_LIMIT && !dropped; i++) begin
      @(negedge clk_25mhz);
      dropped = drv_en_n;
    end
    if (!dropped) begin
      abort_run("drv_en_n did not rise after enable was cleared");
    end
    @(posedge clk_25mhz);
    edges = edge_cycle.size();
    assert (edges < 200) else report_mismatch("move ran to completion after disable");
    // quiet window of several periods
    repeat (200) @(posedge clk_25mhz);
    assert (edge_cycle.size() == edges) else report_mismatch("steps kept coming after disable");
    expected_pos = direction ? pos_before - edges : pos_before + edges;
    bus_read(REG_POSITION, rd);
    assert (signed'(rd) == expected_pos)
      else report_mismatch($sformatf("position %0d, expected %0d", signed'(rd), expected_pos));
    // move request while the driver is off
    edge_cycle.delete();
    bus_write(REG_STEPS, 10);
    repeat (200) @(posedge clk_25mhz);
    assert (edge_cycle.size() == 0) else report_mismatch("steps while disabled");
    bus_read(REG_STATUS, rd);
    assert (rd[1:0] == 2'b00) else report_mismatch($sformatf("status %h while disabled", rd));
  endtask

  initial begin
    void'($urandom(32'h3d85));
    clk_25mhz = 1'b0;
    arst_n    = 1'b0;
    host_req  = '0;
    cycle_cnt = 0;
    step_q    = 1'b0;
    repeat (10) @(posedge clk_25mhz);
    #1;
    arst_n = 1'b1;
    reset_levels();
    register_readback();
    spi_round_trip();
    enable_sequencing();
    counted_move();
    disable_mid_move();
    $display("Everything OK");
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    abort_run("the watchdog expired before the tests finished");
  end

endmodule

// File: sources.f
+incdir+common
common/stepper_pkg.sv
logic/io_register.sv
motor/motor_driver.sv
motor/spi_shift.sv
motor/step_gen.sv
stepper_top.sv
bench/driver_chip_model.sv
bench/stepper_tb.sv

// File: Bender.yml
package:
  name: stepper_axis

sources:
  - include_dirs:
      - common
    files:
      - common/stepper_pkg.sv
      - logic/io_register.sv
      - motor/motor_driver.sv
      - motor/spi_shift.sv
      - motor/step_gen.sv
      - stepper_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/driver_chip_model.sv
      - bench/stepper_tb.sv
